/* src/pool_pkg.sv */
package pool_pkg;

	// Bus and datapath widths
	localparam int DATA_W    = 16;
	localparam int ADDR_W    = 16;
	localparam int MAX_SHIFT = 3;   // Largest window exponent, 8 bursts

	// Feature word as read from and written to memory
	typedef logic signed [DATA_W-1:0] data_t;

	// Window sum, wide enough for 2^MAX_SHIFT words
	typedef logic signed [DATA_W+MAX_SHIFT-1:0] sum_t;

	typedef logic [ADDR_W-1:0] addr_t;  // Word address
	typedef logic [1:0] shift_t;        // Window is 2^shift bursts
	typedef logic [7:0] count_t;        // Groups per job

	// Reduction applied by every lane
	typedef enum logic {
		OP_MAX,
		OP_AVG
	} pool_op_t;

	// Job sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,    // Fetch one window of bursts
		ST_REDUCE,  // Burst register and lane update
		ST_WRITE,   // Store LANES results
		ST_DONE
	} seq_state_t;

endpackage

/* src/pool_sequencer.sv */
`timescale 1ns/1ps

module pool_sequencer #(
	parameter int LANES = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                i_start,
	input  pool_pkg::pool_op_t  i_op,
	input  pool_pkg::shift_t    i_shift,
	input  pool_pkg::count_t    i_groups,
	input  pool_pkg::addr_t     i_src_addr,
	input  pool_pkg::addr_t     i_dst_addr,
	input  logic                i_wb_ack,
	input  logic                i_last_word,
	output logic                o_wb_cyc,
	output logic                o_wb_stb,
	output logic                o_wb_we,
	output pool_pkg::addr_t     o_wb_adr,
	output logic                o_rd_ack,
	output logic                o_wr_ack,
	output logic                o_first,
	output logic                o_capture,
	output logic                o_busy,
	output logic                o_done,
	output pool_pkg::pool_op_t  o_op,
	output pool_pkg::shift_t    o_shift
);
	import pool_pkg::*;

	// Word counter covers the largest window
	localparam int WCNT_W = $clog2(LANES) + MAX_SHIFT;

	seq_state_t        state;
	logic              stb_q;      // Drives both cyc and stb
	logic              we_q;
	logic              ack_q;      // Ack of our own strobe
	logic              red_cnt;    // Cycle within ST_REDUCE
	logic              first_q;
	addr_t             rd_addr;
	addr_t             wr_addr;
	logic [WCNT_W-1:0] wcnt;       // Word within the window
	logic [WCNT_W-1:0] win_last;
	count_t            gcnt;
	count_t            groups_q;

	assign win_last = WCNT_W'((LANES << o_shift) - 1); // LANES * 2^shift words

	assign ack_q    = stb_q & i_wb_ack;
	assign o_rd_ack = ack_q & (state == ST_READ);
	assign o_wr_ack = ack_q & (state == ST_WRITE);

	assign o_wb_cyc = stb_q;   // Single transfers, cyc follows stb
	assign o_wb_stb = stb_q;
	assign o_wb_we  = we_q;
	assign o_wb_adr = we_q ? wr_addr : rd_addr; // Counters move only on ack

	assign o_first   = first_q;
	assign o_capture = (state == ST_REDUCE) & red_cnt; // Lanes settled
	assign o_busy    = (state != ST_IDLE) && (state != ST_DONE);
	assign o_done    = (state == ST_DONE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= ST_IDLE;
			stb_q    <= 1'b0;
			we_q     <= 1'b0;
			red_cnt  <= 1'b0;
			first_q  <= 1'b0;
			rd_addr  <= '0;
			wr_addr  <= '0;
			wcnt     <= '0;
			gcnt     <= '0;
			groups_q <= '0;
			o_op     <= OP_MAX;
			o_shift  <= '0;
		end else begin
			// Strobe drops on ack and stays low at least one cycle
			if (ack_q) begin
				stb_q <= 1'b0;
				we_q  <= 1'b0;
			end else if (!stb_q && (state == ST_READ || state == ST_WRITE)) begin
				stb_q <= 1'b1;
				we_q  <= (state == ST_WRITE);
			end

			case (state)
				ST_IDLE: begin
					if (i_start) begin
						// Latch the job
						o_op     <= i_op;
						o_shift  <= i_shift;
						groups_q <= i_groups;
						rd_addr  <= i_src_addr;
						wr_addr  <= i_dst_addr;
						wcnt     <= '0;
						gcnt     <= '0;
						first_q  <= 1'b1;
						state    <= (i_groups == '0) ? ST_DONE : ST_READ; // Empty job
					end
				end
				ST_READ: begin
					if (o_rd_ack) begin
						rd_addr <= rd_addr + 1'b1; // Source is contiguous
						wcnt    <= wcnt + 1'b1;
						// First word of the second burst ends the load phase
						if (wcnt == WCNT_W'(LANES))
							first_q <= 1'b0;
						if (wcnt == win_last) begin
							wcnt    <= '0;
							red_cnt <= 1'b0;
							state   <= ST_REDUCE;
						end
					end
				end
				ST_REDUCE: begin
					red_cnt <= 1'b1;
					if (red_cnt)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					if (o_wr_ack) begin
						wr_addr <= wr_addr + 1'b1;
						if (i_last_word) begin
							gcnt    <= gcnt + 1'b1;
							first_q <= 1'b1; // Next window starts fresh
							state   <= (gcnt == groups_q - 1'b1) ? ST_DONE : ST_READ;
						end
					end
				end
				ST_DONE: state <= ST_IDLE; // One cycle done pulse
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* src/burst_deserializer.sv */
`timescale 1ns/1ps

module burst_deserializer #(
	parameter int LANES = 4
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_rd_ack,
	input  pool_pkg::data_t               i_rd_data,
	output logic                          o_burst_valid,
	output pool_pkg::data_t [LANES-1:0]   o_burst
);

	localparam int CNT_W = (LANES > 1) ? $clog2(LANES) : 1;

	logic [CNT_W-1:0] cnt; // Words of the current burst

	// Shift toward lane 0, first word of a burst ends in lane 0
	always_ff @(posedge clk) begin
		if (i_rd_ack) begin
			for (int l = 0; l < LANES - 1; l++)
				o_burst[l] <= o_burst[l+1];
			o_burst[LANES-1] <= i_rd_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt           <= '0;
			o_burst_valid <= 1'b0;
		end else begin
			o_burst_valid <= i_rd_ack && (cnt == CNT_W'(LANES - 1)); // Full burst next cycle
			if (i_rd_ack)
				cnt <= (cnt == CNT_W'(LANES - 1)) ? '0 : cnt + 1'b1;
		end
	end

endmodule

/* src/pool_lane.sv */
`timescale 1ns/1ps

module pool_lane (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_load,
	input  logic               i_first,
	input  pool_pkg::pool_op_t i_op,
	input  pool_pkg::shift_t   i_shift,
	input  pool_pkg::data_t    i_data,
	output pool_pkg::data_t    o_result
);
	import pool_pkg::*;

	sum_t acc;       // Running max or running sum
	sum_t data_ext;
	sum_t avg;

	assign data_ext = sum_t'(i_data); // Sign extend into accumulator width

	// Arithmetic shift gives the floor, also for negative sums
	assign avg = acc >>> i_shift;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else if (i_load) begin
			if (i_first) begin
				acc <= data_ext;          // First burst of the window
			end else if (i_op == OP_MAX) begin
				if (data_ext > acc)
					acc <= data_ext;      // Signed compare
			end else begin
				acc <= acc + data_ext;    // Cannot overflow within 8 bursts
			end
		end
	end

	// Max fits in 16 bits, average is back in range after the shift
	assign o_result = (i_op == OP_MAX) ? data_t'(acc) : data_t'(avg);

endmodule

/* src/result_serializer.sv */
`timescale 1ns/1ps

module result_serializer #(
	parameter int LANES = 4
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_capture,
	input  logic                          i_wr_ack,
	input  pool_pkg::data_t [LANES-1:0]   i_results,
	output pool_pkg::data_t               o_wr_data,
	output logic                          o_last_word
);
	import pool_pkg::*;

	localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

	data_t [LANES-1:0] hold;   // Snapshot of all lane results
	logic [IDX_W-1:0]  idx;    // Word being written

	always_ff @(posedge clk) begin
		if (i_capture)
			hold <= i_results;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
		end else if (i_capture) begin
			idx <= '0;
		end else if (i_wr_ack) begin
			// Wrap after the last lane
			idx <= o_last_word ? '0 : idx + 1'b1;
		end
	end

	assign o_wr_data   = hold[idx];
	assign o_last_word = (idx == IDX_W'(LANES - 1));

endmodule

/* src/pool_engine.sv */
`timescale 1ns/1ps

module pool_engine #(
	parameter int LANES = 4
) (
	input  logic               clk,
	input  logic               rst,
	// Job control
	input  logic               i_start,
	input  pool_pkg::pool_op_t i_op,
	input  pool_pkg::shift_t   i_shift,
	input  pool_pkg::count_t   i_groups,
	input  pool_pkg::addr_t    i_src_addr,
	input  pool_pkg::addr_t    i_dst_addr,
	output logic               o_busy,
	output logic               o_done,
	// Wishbone classic master
	output logic               o_wb_cyc,
	output logic               o_wb_stb,
	output logic               o_wb_we,
	output pool_pkg::addr_t    o_wb_adr,
	output pool_pkg::data_t    o_wb_dat,
	input  pool_pkg::data_t    i_wb_dat,
	input  logic               i_wb_ack
);
	import pool_pkg::*;

	logic              rd_ack;
	logic              wr_ack;
	logic              first;
	logic              capture;
	logic              last_word;
	pool_op_t          op;
	shift_t            shift;
	logic              burst_valid;
	data_t [LANES-1:0] burst;
	data_t [LANES-1:0] results;

	pool_sequencer #(
		.LANES (LANES)
	) u_seq (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_start),
		.i_op        (i_op),
		.i_shift     (i_shift),
		.i_groups    (i_groups),
		.i_src_addr  (i_src_addr),
		.i_dst_addr  (i_dst_addr),
		.i_wb_ack    (i_wb_ack),
		.i_last_word (last_word),
		.o_wb_cyc    (o_wb_cyc),
		.o_wb_stb    (o_wb_stb),
		.o_wb_we     (o_wb_we),
		.o_wb_adr    (o_wb_adr),
		.o_rd_ack    (rd_ack),
		.o_wr_ack    (wr_ack),
		.o_first     (first),
		.o_capture   (capture),
		.o_busy      (o_busy),
		.o_done      (o_done),
		.o_op        (op),
		.o_shift     (shift)
	);

	// Read words straight from the bus
	burst_deserializer #(
		.LANES (LANES)
	) u_deser (
		.clk           (clk),
		.rst           (rst),
		.i_rd_ack      (rd_ack),
		.i_rd_data     (i_wb_dat),
		.o_burst_valid (burst_valid),
		.o_burst       (burst)
	);

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		pool_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.i_load   (burst_valid),
			.i_first  (first),
			.i_op     (op),
			.i_shift  (shift),
			.i_data   (burst[l]),
			.o_result (results[l])
		);
	end

	result_serializer #(
		.LANES (LANES)
	) u_ser (
		.clk         (clk),
		.rst         (rst),
		.i_capture   (capture),
		.i_wr_ack    (wr_ack),
		.i_results   (results),
		.o_wr_data   (o_wb_dat),  // Held stable until write ack
		.o_last_word (last_word)
	);

endmodule

/* testbench/pool_engine_props.sv */
`timescale 1ns/1ps

module pool_engine_props (
	input logic            clk,
	input logic            rst,
	input logic            i_cyc,
	input logic            i_stb,
	input logic            i_we,
	input pool_pkg::addr_t i_adr,
	input pool_pkg::data_t i_dat,
	input logic            i_ack,
	input logic            i_done
);

	// Strobe only inside an open bus cycle
	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) i_stb |-> i_cyc)
		else $error("stb high without cyc");

	// Stalled transfer keeps its request
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		i_stb && !i_ack |=> i_stb && $stable(i_adr) && $stable(i_we) &&
			(!i_we || $stable(i_dat)))
		else $error("request changed during wait state");

	a_stb_drop: assert property (@(posedge clk) disable iff (rst) i_stb && i_ack |=> !i_stb)
		else $error("stb still high after ack");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
		else $error("done longer than one cycle");

endmodule

bind pool_engine pool_engine_props u_props (
	.clk    (clk),
	.rst    (rst),
	.i_cyc  (o_wb_cyc),
	.i_stb  (o_wb_stb),
	.i_we   (o_wb_we),
	.i_adr  (o_wb_adr),
	.i_dat  (o_wb_dat),
	.i_ack  (i_wb_ack),
	.i_done (o_done)
);

/* testbench/tb_pool_engine.sv */
`timescale 1ns/1ps

module tb_pool_engine;
	import pool_pkg::*;

	localparam int LANES   = 4;
	localparam int NJOBS   = 8;
	localparam int TIMEOUT = 5000;  // Cycles per job

	typedef struct {
		pool_op_t op;
		int       shift;
		int       groups;
		int       src;
		int       dst;
		int       writes;  // Bus writes expected for the job
	} job_t;

	// Source windows and destinations never overlap
	job_t jobs [NJOBS] = '{
		'{OP_MAX, 1, 2, 'h000, 'h300, 8},
		'{OP_MAX, 2, 2, 'h040, 'h310, 8},
		'{OP_MAX, 3, 2, 'h080, 'h320, 8},
		'{OP_AVG, 1, 3, 'h0c0, 'h330, 12},
		'{OP_AVG, 2, 2, 'h100, 'h340, 8},
		'{OP_AVG, 3, 3, 'h140, 'h350, 12},
		'{OP_MAX, 0, 4, 'h1a0, 'h360, 16},  // Plain copy
		'{OP_AVG, 0, 5, 'h1c0, 'h380, 20}
	};

	logic     clk;
	logic     rst;
	logic     i_start;
	pool_op_t i_op;
	shift_t   i_shift;
	count_t   i_groups;
	addr_t    i_src_addr;
	addr_t    i_dst_addr;
	logic     o_busy;
	logic     o_done;
	logic     o_wb_cyc;
	logic     o_wb_stb;
	logic     o_wb_we;
	addr_t    o_wb_adr;
	data_t    o_wb_dat;
	data_t    i_wb_dat;
	logic     i_wb_ack;

	data_t mem [1024];        // Bus memory image
	data_t exp_q [$];         // Expected destination words
	int    seed = 32'h0a48_8f1e;
	int    wait_left;
	logic  in_xfer;
	int    writes;
	int    dones;

	pool_engine #(.LANES(LANES)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Memory slave with 0 to 3 wait states per strobe
	always @(posedge clk) begin
		#1;
		if (i_wb_ack) begin
			i_wb_ack = 1'b0;  // Single cycle ack
		end else if (o_wb_cyc && o_wb_stb) begin
			if (!in_xfer) begin
				in_xfer   = 1'b1;
				wait_left = $random(seed) & 3;
			end
			if (wait_left == 0) begin
				in_xfer  = 1'b0;
				i_wb_ack = 1'b1;
				if (o_wb_we) begin
					mem[o_wb_adr[9:0]] = o_wb_dat;
					writes++;
				end else begin
					i_wb_dat = mem[o_wb_adr[9:0]];
				end
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge clk)
		if (o_done)
			dones++;

	task automatic step_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_failure;
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(string name, logic signed [31:0] got, logic signed [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_quiet;
		check_value("o_busy", o_busy, 0);
		check_value("o_done", o_done, 0);
		check_value("o_wb_cyc", o_wb_cyc, 0);
		check_value("o_wb_stb", o_wb_stb, 0);
		check_value("o_wb_we", o_wb_we, 0);
	endtask

	// Window reduction straight from the pooling rules
	function automatic data_t ref_word(pool_op_t op, int shift, int src, int g, int l);
		int win;
		int w;
		int v;
		int acc;
		int q;
		win = 1 << shift;
		acc = 0;
		for (w = 0; w < win; w++) begin
			v = mem[src + (g * win + w) * LANES + l];
			if (w == 0)
				acc = v;
			else if (op == OP_MAX)
				acc = (v > acc) ? v : acc;
			else
				acc = acc + v;
		end
		if (op == OP_MAX)
			return data_t'(acc);
		q = acc / win;       // Rounds toward zero
		if (q * win > acc)
			q = q - 1;       // Floor for negative sums
		return data_t'(q);
	endfunction

	initial begin
		int    j;
		int    k;
		int    cycles;
		int    base;
		data_t guard0;
		data_t guard1;

		rst        = 1'b1;
		i_start    = 1'b0;
		i_op       = OP_MAX;
		i_shift    = '0;
		i_groups   = '0;
		i_src_addr = '0;
		i_dst_addr = '0;
		i_wb_dat   = '0;
		i_wb_ack   = 1'b0;
		in_xfer    = 1'b0;
		wait_left  = 0;
		writes     = 0;
		dones      = 0;
		for (k = 0; k < 1024; k++)
			mem[k] = data_t'($random(seed));

		repeat (3) begin
			step_cycle();
			check_quiet();  // Held in reset
		end
		rst = 1'b0;
		step_cycle();
		check_quiet();

		for (j = 0; j < NJOBS; j++) begin
			exp_q.delete();
			for (k = 0; k < jobs[j].groups * LANES; k++)
				exp_q.push_back(ref_word(jobs[j].op, jobs[j].shift, jobs[j].src,
					k / LANES, k % LANES));
			base   = jobs[j].dst + jobs[j].writes;
			guard0 = mem[base];      // Words just past the destination
			guard1 = mem[base + 1];
			writes = 0;
			dones  = 0;

			i_op       = jobs[j].op;
			i_shift    = shift_t'(jobs[j].shift);
			i_groups   = count_t'(jobs[j].groups);
			i_src_addr = addr_t'(jobs[j].src);
			i_dst_addr = addr_t'(jobs[j].dst);
			i_start    = 1'b1;
			step_cycle();
			check_value("o_busy", o_busy, 1);
			step_cycle();            // Start still high while busy
			i_start = 1'b0;

			cycles = 0;
			while (o_done !== 1'b1) begin
				check_value("o_busy", o_busy, 1);
				i_start = (cycles == 20);  // Stray start mid-job
				step_cycle();
				cycles++;
				if (cycles > TIMEOUT) begin
					$display("Timeout at %0t: o_done never rose for job %0d", $time, j);
					stop_on_failure();
				end
			end
			i_start = 1'b0;
			check_value("o_busy", o_busy, 0);

			repeat (10) step_cycle();
			check_quiet();
			check_value("done pulses", dones, 1);
			check_value("bus writes", writes, jobs[j].writes);
			for (k = 0; k < exp_q.size(); k++)
				check_value($sformatf("mem[0x%03h]", jobs[j].dst + k),
					mem[jobs[j].dst + k], exp_q[k]);
			check_value($sformatf("mem[0x%03h]", base), mem[base], guard0);
			check_value($sformatf("mem[0x%03h]", base + 1), mem[base + 1], guard1);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* sources.f */
src/pool_pkg.sv
src/pool_sequencer.sv
src/burst_deserializer.sv
src/pool_lane.sv
src/result_serializer.sv
src/pool_engine.sv
testbench/pool_engine_props.sv
testbench/tb_pool_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pool_engine
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
